// File: alu_lane/alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module alu_core (
    input  logic [31:0]           op1,
    input  logic [31:0]           op2,
    input  logic [31:0]           instr,
    output logic [31:0]           result,
    output logic [31:0]           hi,
    output logic [31:0]           lo,
    output logic [31:0]           memaddr,
    output logic                  b_flag,
    output logic                  writes_hi,
    output logic                  writes_lo,
    output exec_pkg::result_src_e result_src,
    output logic                  is_divide,
    output logic                  div_signed
);
    import mips_isa_pkg::*;
    import exec_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    regimm_e     rt;
    logic [4:0]  shamt;
    logic [31:0] simm, uimm;

    assign opcode = opcode_e'(instr[OPCODE_LSB +: 6]);
    assign funct  = funct_e'(instr[FUNCT_LSB +: 6]);
    assign rt     = regimm_e'(instr[RT_LSB +: 5]);
    assign shamt  = instr[SHAMT_LSB +: 5];
    assign simm   = {{16{instr[IMM_LSB + 15]}}, instr[IMM_LSB +: 16]};
    assign uimm   = {16'b0, instr[IMM_LSB +: 16]};

    always_comb begin
        result     = '0;
        hi         = '0;
        lo         = '0;
        memaddr    = '0;
        b_flag     = 1'b0;
        writes_hi  = 1'b0;
        writes_lo  = 1'b0;
        result_src = SRC_ALU;
        is_divide  = 1'b0;
        div_signed = 1'b0;
        case (opcode)
            SPECIAL: begin
                case (funct)
                    SLL:   result = op2 << shamt;
                    SRL:   result = op2 >> shamt;
                    SRA:   result = $signed(op2) >>> shamt;
                    SLLV:  result = op2 << op1[4:0]; // low five bits only
                    SRLV:  result = op2 >> op1[4:0];
                    SRAV:  result = $signed(op2) >>> op1[4:0];
                    MFHI:  result_src = SRC_HI;
                    MFLO:  result_src = SRC_LO;
                    MTHI:  {writes_hi, hi} = {1'b1, op1};
                    MTLO:  {writes_lo, lo} = {1'b1, op1};
                    MULT:  {hi, lo} = $signed(op1) * $signed(op2);
                    MULTU: {hi, lo} = op1 * op2;
                    DIV:   {is_divide, div_signed} = 2'b11;
                    DIVU:  is_divide = 1'b1;
                    ADD, ADDU: result = op1 + op2; // no overflow trap
                    SUB, SUBU: result = op1 - op2;
                    AND:   result = op1 & op2;
                    OR:    result = op1 | op2;
                    XOR:   result = op1 ^ op2;
                    NOR:   result = ~(op1 | op2);
                    SLT:   result = {31'b0, $signed(op1) < $signed(op2)};
                    SLTU:  result = {31'b0, op1 < op2};
                    default: ;
                endcase
                if (funct inside {MULT, MULTU, DIV, DIVU}) begin
                    writes_hi = 1'b1;
                    writes_lo = 1'b1;
                end
            end
            REGIMM: begin
                case (rt)
                    BLTZ, BLTZAL: b_flag = op1[31];
                    BGEZ, BGEZAL: b_flag = ~op1[31];
                    default: ;
                endcase
            end
            BEQ:         b_flag = (op1 == op2);
            BNE:         b_flag = (op1 != op2);
            BLEZ:        b_flag = op1[31] | (op1 == '0);
            BGTZ:        b_flag = ~op1[31] & (op1 != '0);
            ADDI, ADDIU: result = op1 + simm;
            SLTI:        result = {31'b0, $signed(op1) < $signed(simm)};
            SLTIU:       result = {31'b0, op1 < simm}; // sign-extended, compared unsigned
            ANDI:        result = op1 & uimm;
            ORI:         result = op1 | uimm;
            XORI:        result = op1 ^ uimm;
            LUI:         result = uimm << 16;
            LB, LH, LW, LBU, LHU, SB, SH, SW: memaddr = op1 + simm;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: alu_lane/alu_lane.sv
`timescale 1ns/10ps
`default_nettype none

module alu_lane (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  logic [31:0]           issue_op1,
    input  logic [31:0]           issue_op2,
    input  logic [31:0]           issue_instr,
    input  logic                  done_ack,
    output logic                  busy,
    output logic                  done,
    output logic [31:0]           done_result,
    output logic [31:0]           done_memaddr,
    output logic                  done_bflag,
    output logic [31:0]           done_hi,
    output logic [31:0]           done_lo,
    output logic                  done_writes_hi,
    output logic                  done_writes_lo,
    output exec_pkg::result_src_e done_src
);
    import exec_pkg::*;

    lane_state_e state;
    result_src_e core_src;
    logic [31:0] core_result, core_hi, core_lo, core_memaddr;
    logic        core_bflag, core_writes_hi, core_writes_lo, is_divide, div_signed;
    logic [31:0] divisor;
    logic [5:0]  step;
    logic        neg_quot, neg_rem;
    logic [32:0] trial, diff;

    alu_core u_core (
        .op1        (issue_op1),
        .op2        (issue_op2),
        .instr      (issue_instr),
        .result     (core_result),
        .hi         (core_hi),
        .lo         (core_lo),
        .memaddr    (core_memaddr),
        .b_flag     (core_bflag),
        .writes_hi  (core_writes_hi),
        .writes_lo  (core_writes_lo),
        .result_src (core_src),
        .is_divide  (is_divide),
        .div_signed (div_signed)
    );

    // restoring divide with the partial remainder in hi and the quotient shifting into lo
    assign trial = {done_hi, done_lo[31]};
    assign diff  = trial - {1'b0, divisor};
    assign busy  = (state != LANE_IDLE);
    assign done  = (state == LANE_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LANE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (issue_valid) state <= is_divide ? LANE_DIV : LANE_DONE;
                    step <= '0;
                end
                LANE_DIV: begin
                    if (step == 6'd32) state <= LANE_DONE; // sign fix-up cycle
                    step <= step + 1'b1;
                end
                LANE_DONE: if (done_ack) state <= LANE_IDLE;
                default:   state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && issue_valid) begin
            done_result    <= core_result;
            done_memaddr   <= core_memaddr;
            done_bflag     <= core_bflag;
            done_writes_hi <= core_writes_hi;
            done_writes_lo <= core_writes_lo;
            done_src       <= core_src;
            divisor        <= (div_signed && issue_op2[31]) ? -issue_op2 : issue_op2;
            neg_quot       <= div_signed & (issue_op1[31] ^ issue_op2[31]) & (issue_op2 != '0);
            neg_rem        <= div_signed & issue_op1[31]; // remainder follows dividend
            done_hi        <= is_divide ? '0 : core_hi;
            if (is_divide) done_lo <= (div_signed && issue_op1[31]) ? -issue_op1 : issue_op1;
            else done_lo <= core_lo;
        end else if (state == LANE_DIV) begin
            if (step == 6'd32) begin
                done_hi <= neg_rem ? -done_hi : done_hi;
                done_lo <= neg_quot ? -done_lo : done_lo;
            end else begin
                done_hi <= diff[32] ? trial[31:0] : diff[31:0]; // restore on borrow
                done_lo <= {done_lo[30:0], ~diff[32]};
            end
        end
    end

endmodule

`default_nettype wire

// File: common/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // word offsets on the APB side
    typedef enum logic [5:0] {
        REG_OP1     = 6'h00,
        REG_OP2     = 6'h04,
        REG_INSTR   = 6'h08,
        REG_RESULT  = 6'h0C,
        REG_MEMADDR = 6'h10,
        REG_BFLAG   = 6'h14,
        REG_HI      = 6'h18,
        REG_LO      = 6'h1C,
        REG_STATUS  = 6'h20
    } reg_addr_e;

    typedef enum logic [1:0] {LANE_IDLE, LANE_DIV, LANE_DONE} lane_state_e;

    typedef enum logic [1:0] {SRC_ALU, SRC_HI, SRC_LO} result_src_e;

endpackage

`default_nettype wire

// File: common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int RT_LSB     = 16;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;

    typedef enum logic [5:0] {
        SPECIAL = 6'd0,  REGIMM = 6'd1,
        BEQ     = 6'd4,  BNE    = 6'd5,  BLEZ  = 6'd6,  BGTZ = 6'd7,
        ADDI    = 6'd8,  ADDIU  = 6'd9,  SLTI  = 6'd10, SLTIU = 6'd11,
        ANDI    = 6'd12, ORI    = 6'd13, XORI  = 6'd14, LUI  = 6'd15,
        LB      = 6'd32, LH     = 6'd33, LW    = 6'd35, LBU  = 6'd36,
        LHU     = 6'd37, SB     = 6'd40, SH    = 6'd41, SW   = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        SLL  = 6'd0,  SRL   = 6'd2,  SRA  = 6'd3,  SLLV  = 6'd4,
        SRLV = 6'd6,  SRAV  = 6'd7,
        MFHI = 6'd16, MTHI  = 6'd17, MFLO = 6'd18, MTLO  = 6'd19,
        MULT = 6'd24, MULTU = 6'd25, DIV  = 6'd26, DIVU  = 6'd27,
        ADD  = 6'd32, ADDU  = 6'd33, SUB  = 6'd34, SUBU  = 6'd35,
        AND  = 6'd36, OR    = 6'd37, XOR  = 6'd38, NOR   = 6'd39,
        SLT  = 6'd42, SLTU  = 6'd43
    } funct_e;

    // rt field of REGIMM branches
    typedef enum logic [4:0] {
        BLTZ   = 5'd0,
        BGEZ   = 5'd1,
        BLTZAL = 5'd16,
        BGEZAL = 5'd17
    } regimm_e;

endpackage

`default_nettype wire

// File: mips_exec.f
common/mips_isa_pkg.sv
common/exec_pkg.sv
verilog/apb_exec_regs.sv
verilog/lane_dispatch.sv
alu_lane/alu_core.sv
alu_lane/alu_lane.sv
verilog/result_collect.sv
verilog/mips_exec_top.sv
test/tb_mips_exec.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mips_exec \
    -f mips_exec.f -o tb_mips_exec

./obj_dir/tb_mips_exec > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// File: test/exec_cases.txt
// columns: op1 op2 instr result memaddr bflag hi lo (hex), hi and lo after the case retires
// the last four lines are issued back to back without reading in between
00000005 00000007 00000021 0000000C 00000000 00000000 00000000 00000000 // addu
7FFFFFFF 00000001 00000020 80000000 00000000 00000000 00000000 00000000 // add wraps
00000000 80000010 00000103 F8000001 00000000 00000000 00000000 00000000 // sra 4
00000024 F0000000 00000007 FF000000 00000000 00000000 00000000 00000000 // srav
FFFFFFFF 00000001 0000002A 00000001 00000000 00000000 00000000 00000000 // slt
FFFFFFFF 00000001 0000002B 00000000 00000000 00000000 00000000 00000000 // sltu
00000000 00000000 3C001234 12340000 00000000 00000000 00000000 00000000 // lui
00000010 00000000 2000FFFF 0000000F 00000000 00000000 00000000 00000000 // addi -1
00000005 00000000 2C00FFFF 00000001 00000000 00000000 00000000 00000000 // sltiu
00000055 00000055 10000000 00000000 00000000 00000001 00000000 00000000 // beq
80000000 00000000 1C000000 00000000 00000000 00000000 00000000 00000000 // bgtz
FFFFFFFE 00000000 04000000 00000000 00000000 00000001 00000000 00000000 // bltz
00001000 00000000 8C00FFFC 00000000 00000FFC 00000000 00000000 00000000 // lw
80000000 00000000 AC000010 00000000 80000010 00000000 00000000 00000000 // sw
FFFFFFFE 00000003 00000018 00000000 00000000 00000000 FFFFFFFF FFFFFFFA // mult
FFFFFFFF 00000002 00000019 00000000 00000000 00000000 00000001 FFFFFFFE // multu
FFFFFFF9 00000002 0000001A 00000000 00000000 00000000 FFFFFFFF FFFFFFFD // div -7/2
00000064 00000007 0000001B 00000000 00000000 00000000 00000002 0000000E // divu
FFFFFFF7 00000000 0000001A 00000000 00000000 00000000 FFFFFFF7 FFFFFFFF // div by zero
00000011 00000005 0000001A 00000000 00000000 00000000 00000002 00000003 // div 17/5
13579BDF 00000000 00000013 00000000 00000000 00000000 00000002 13579BDF // mtlo
00000000 00000000 00000012 13579BDF 00000000 00000000 00000002 13579BDF // mflo
00000100 00000023 00000020 00000123 00000000 00000000 00000002 13579BDF // add

// File: test/tb_mips_exec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_exec;

    localparam int NUM_LANES    = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int NUM_CASES    = 23;
    localparam int REPLAY_CASES = 19; // the rest are issued back to back
    localparam int FIELDS       = 8;
    localparam int TIMEOUT      = 200;
    localparam int STALL_CYCLES = 100;

    logic        clk;
    logic        reset;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] case_mem [NUM_CASES * FIELDS];
    logic [15:0] lfsr;
    int          value_errors;
    int          other_errors;

    mips_exec_top #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // 0 to 3 idle cycles drawn from two LFSR bits
    task automatic idle_gap();
        int n;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_next(lfsr);
            n = n * 2 + int'(lfsr[0]);
        end
        repeat (n) @(posedge clk);
    endtask

    task automatic apb_xfer(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            input int limit, output logic [31:0] rdata, output logic err,
                            output logic completed);
        int waited;
        completed = 1'b0;
        rdata     = '0;
        err       = 1'b0;
        waited    = 0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        while (!completed && waited < limit) begin
            @(negedge clk); // sample away from the driving edge
            if (pready) begin
                completed = 1'b1;
                rdata     = prdata;
                err       = pslverr;
            end
            waited++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        logic        completed;
        idle_gap();
        apb_xfer(addr, 1'b1, data, TIMEOUT, rdata, err, completed);
        if (!completed) begin
            $display("APB write to offset %h timed out waiting for pready", addr);
            other_errors++;
        end else if (err) begin
            $display("APB write to offset %h answered with a slave error", addr);
            other_errors++;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        logic completed;
        idle_gap();
        apb_xfer(addr, 1'b0, 32'h0, TIMEOUT, data, err, completed);
        if (!completed) begin
            $display("APB read of offset %h timed out waiting for pready", addr);
            other_errors++;
        end else if (err) begin
            $display("APB read of offset %h answered with a slave error", addr);
            other_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic issue_case(input int idx);
        write_reg(8'h00, case_mem[idx * FIELDS]);
        write_reg(8'h04, case_mem[idx * FIELDS + 1]);
        write_reg(8'h08, case_mem[idx * FIELDS + 2]); // issues
    endtask

    task automatic wait_fifo_entry();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[0] && polls < TIMEOUT) begin
            read_reg(8'h20, status);
            polls++;
        end
        if (!status[0]) begin
            $display("no result entry showed up in the FIFO");
            other_errors++;
        end
    endtask

    task automatic pop_and_check(input int idx);
        logic [31:0] data;
        wait_fifo_entry();
        read_reg(8'h0C, data);
        check_word("RESULT", case_mem[idx * FIELDS + 3], data);
        read_reg(8'h10, data);
        check_word("MEMADDR", case_mem[idx * FIELDS + 4], data);
        read_reg(8'h14, data);
        check_word("BFLAG", case_mem[idx * FIELDS + 5], data);
    endtask

    task automatic check_hilo(input int idx);
        logic [31:0] data;
        read_reg(8'h18, data);
        check_word("HI", case_mem[idx * FIELDS + 6], data);
        read_reg(8'h1C, data);
        check_word("LO", case_mem[idx * FIELDS + 7], data);
    endtask

    task automatic check_error_response(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        logic        completed;
        idle_gap();
        apb_xfer(addr, 1'b0, 32'h0, TIMEOUT, rdata, err, completed);
        if (!completed) begin
            $display("APB read of offset %h never completed", addr);
            other_errors++;
        end else begin
            check_word("pslverr", 32'd1, {31'b0, err});
            check_word("prdata", 32'd0, rdata);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic        completed;
        int          stalled;
        clk          = 1'b0;
        reset        = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        lfsr         = 16'd16415;
        value_errors = 0;
        other_errors = 0;
        stalled      = NUM_LANES + FIFO_DEPTH;
        $readmemh("test/exec_cases.txt", case_mem);
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < REPLAY_CASES; i++) begin
            issue_case(i);
            pop_and_check(i);
            check_hilo(i);
        end

        // div, mtlo, mflo, add all in flight together
        for (int i = REPLAY_CASES; i < NUM_CASES; i++) issue_case(i);
        for (int i = REPLAY_CASES; i < NUM_CASES; i++) pop_and_check(i);
        check_hilo(NUM_CASES - 1);

        // fill every lane and the FIFO, then one more
        for (int i = 0; i < stalled; i++) issue_case(i);
        write_reg(8'h00, case_mem[stalled * FIELDS]);
        write_reg(8'h04, case_mem[stalled * FIELDS + 1]);
        apb_xfer(8'h08, 1'b1, case_mem[stalled * FIELDS + 2], STALL_CYCLES, rdata, err,
                 completed);
        if (completed) begin
            $display("INSTR write completed while all lanes and the FIFO were full");
            other_errors++;
        end
        read_reg(8'h20, rdata);
        check_word("STATUS", {24'b0, 4'(FIFO_DEPTH), 4'b0001},
                   {24'b0, rdata[7:4], 3'b000, rdata[0]}); // full FIFO
        for (int i = 0; i < stalled; i++) pop_and_check(i);
        apb_xfer(8'h08, 1'b1, case_mem[stalled * FIELDS + 2], TIMEOUT, rdata, err, completed);
        if (!completed) begin
            $display("stalled INSTR write did not complete after the FIFO was drained");
            other_errors++;
        end else if (err) begin
            $display("stalled INSTR write answered with a slave error");
            other_errors++;
        end
        pop_and_check(stalled);

        check_error_response(8'h0C); // FIFO is empty here
        check_error_response(8'h24);

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/apb_exec_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_exec_regs #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [7:0]                        paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              issue_valid,
    output logic [31:0]                       issue_op1,
    output logic [31:0]                       issue_op2,
    output logic [31:0]                       issue_instr,
    input  logic                              issue_ready,
    output logic                              fifo_pop,
    input  logic                              fifo_valid,
    input  logic [31:0]                       fifo_result,
    input  logic [31:0]                       fifo_memaddr,
    input  logic                              fifo_bflag,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_count,
    input  logic [31:0]                       hi,
    input  logic [31:0]                       lo
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    reg_addr_e   addr;
    logic        setup, access, mapped, rd_err;
    logic [31:0] op1_q, op2_q, instr_q, memaddr_q, rd_data;
    logic        bflag_q;

    assign addr   = reg_addr_e'(paddr[5:0]);
    assign setup  = psel & ~penable;
    assign access = psel & penable;

    always_comb begin
        mapped  = (paddr[7:6] == 2'b00);
        rd_data = '0;
        case (addr)
            REG_OP1:     rd_data = op1_q;
            REG_OP2:     rd_data = op2_q;
            REG_INSTR:   rd_data = instr_q;
            REG_RESULT:  rd_data = fifo_result; // head of the FIFO
            REG_MEMADDR: rd_data = memaddr_q;
            REG_BFLAG:   rd_data = {31'b0, bflag_q};
            REG_HI:      rd_data = hi;
            REG_LO:      rd_data = lo;
            REG_STATUS: begin
                rd_data[0]          = fifo_valid;
                rd_data[4 +: CNT_W] = fifo_count;
            end
            default:     mapped = 1'b0;
        endcase
    end

    assign rd_err      = ~pwrite & (addr == REG_RESULT) & ~fifo_valid; // pop of empty FIFO
    assign pslverr     = access & (~mapped | rd_err);
    assign prdata      = (access & ~pwrite & ~pslverr) ? rd_data : '0;
    assign issue_valid = access & pwrite & mapped & (addr == REG_INSTR);
    assign pready      = ~(issue_valid & ~issue_ready); // hold INSTR write until a lane is free
    assign fifo_pop    = access & ~pwrite & mapped & (addr == REG_RESULT) & fifo_valid;
    assign issue_op1   = op1_q;
    assign issue_op2   = op2_q;
    assign issue_instr = instr_q;

    always_ff @(posedge clk) begin
        if (access && pwrite && mapped && addr == REG_OP1) op1_q <= pwdata;
        if (access && pwrite && mapped && addr == REG_OP2) op2_q <= pwdata;
        if (setup && pwrite && mapped && addr == REG_INSTR) instr_q <= pwdata; // ready for access
    end

    // address and flag of the entry last popped
    always_ff @(posedge clk) begin
        if (reset) begin
            memaddr_q <= '0;
            bflag_q   <= 1'b0;
        end else if (fifo_pop) begin
            memaddr_q <= fifo_memaddr;
            bflag_q   <= fifo_bflag;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lane_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module lane_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic                 issue_ready,
    output logic [NUM_LANES-1:0] lane_issue_valid
);
    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] ptr;

    assign issue_ready = ~lane_busy[ptr]; // wait on the pointed lane, never skip it

    always_comb begin
        lane_issue_valid      = '0;
        lane_issue_valid[ptr] = issue_valid & issue_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (issue_valid && issue_ready) begin
            ptr <= (ptr == PTR_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mips_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_exec_top #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic                       issue_valid, issue_ready;
    logic [31:0]                issue_op1, issue_op2, issue_instr;
    logic [NUM_LANES-1:0]       lane_issue_valid, lane_busy, done, done_ack;
    logic [NUM_LANES-1:0]       done_bflag, done_writes_hi, done_writes_lo;
    logic [NUM_LANES-1:0][31:0] done_result, done_memaddr, done_hi, done_lo;
    result_src_e [NUM_LANES-1:0] done_src;
    logic                       fifo_pop, fifo_valid, fifo_bflag;
    logic [31:0]                fifo_result, fifo_memaddr, hi, lo;
    logic [CNT_W-1:0]           fifo_count;

    apb_exec_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_apb (.*);

    lane_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (.*);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk            (clk),
            .reset          (reset),
            .issue_valid    (lane_issue_valid[i]),
            .issue_op1      (issue_op1),
            .issue_op2      (issue_op2),
            .issue_instr    (issue_instr),
            .done_ack       (done_ack[i]),
            .busy           (lane_busy[i]),
            .done           (done[i]),
            .done_result    (done_result[i]),
            .done_memaddr   (done_memaddr[i]),
            .done_bflag     (done_bflag[i]),
            .done_hi        (done_hi[i]),
            .done_lo        (done_lo[i]),
            .done_writes_hi (done_writes_hi[i]),
            .done_writes_lo (done_writes_lo[i]),
            .done_src       (done_src[i])
        );
    end

    result_collect #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_collect (.*);

endmodule

`default_nettype wire

// File: verilog/result_collect.sv
`timescale 1ns/10ps
`default_nettype none

module result_collect #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [NUM_LANES-1:0]                  done,
    input  logic [NUM_LANES-1:0][31:0]            done_result,
    input  logic [NUM_LANES-1:0][31:0]            done_memaddr,
    input  logic [NUM_LANES-1:0]                  done_bflag,
    input  logic [NUM_LANES-1:0][31:0]            done_hi,
    input  logic [NUM_LANES-1:0][31:0]            done_lo,
    input  logic [NUM_LANES-1:0]                  done_writes_hi,
    input  logic [NUM_LANES-1:0]                  done_writes_lo,
    input  exec_pkg::result_src_e [NUM_LANES-1:0] done_src,
    input  logic                                  fifo_pop,
    output logic [NUM_LANES-1:0]                  done_ack,
    output logic                                  fifo_valid,
    output logic [31:0]                           fifo_result,
    output logic [31:0]                           fifo_memaddr,
    output logic                                  fifo_bflag,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]       fifo_count,
    output logic [31:0]                           hi,
    output logic [31:0]                           lo
);
    import exec_pkg::*;

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

    logic [LANE_W-1:0]     lane_ptr;
    logic [ADDR_W-1:0]     wr_ptr, rd_ptr;
    logic [31:0]           result_mem [FIFO_DEPTH];
    logic [31:0]           addr_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] flag_mem;
    logic                  push;
    logic [31:0]           push_result;

    assign push         = done[lane_ptr] & (fifo_count != CNT_W'(FIFO_DEPTH)); // retire in order
    assign fifo_valid   = (fifo_count != '0);
    assign fifo_result  = result_mem[rd_ptr];
    assign fifo_memaddr = addr_mem[rd_ptr];
    assign fifo_bflag   = flag_mem[rd_ptr];

    always_comb begin
        done_ack           = '0;
        done_ack[lane_ptr] = push;
        case (done_src[lane_ptr])
            SRC_HI:  push_result = hi; // mfhi sees every earlier write
            SRC_LO:  push_result = lo;
            default: push_result = done_result[lane_ptr];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_ptr   <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            hi         <= '0;
            lo         <= '0;
        end else begin
            if (push) begin
                lane_ptr <= (lane_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
                wr_ptr   <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (done_writes_hi[lane_ptr]) hi <= done_hi[lane_ptr];
                if (done_writes_lo[lane_ptr]) lo <= done_lo[lane_ptr];
            end
            if (fifo_pop) rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fifo_count <= fifo_count + CNT_W'(push) - CNT_W'(fifo_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            result_mem[wr_ptr] <= push_result;
            addr_mem[wr_ptr]   <= done_memaddr[lane_ptr];
            flag_mem[wr_ptr]   <= done_bflag[lane_ptr];
        end
    end

endmodule

`default_nettype wire
